// ==== logic/sampler_params.svh ====
// Sizing macros for the coefficient sampler, included by packages and RTL that need them
`ifndef SAMPLER_PARAMS_SVH
`define SAMPLER_PARAMS_SVH

// Shift buffer holds two input blocks
`define SMP_BUF_W 96

// Host block width, same in both modes
`define SMP_IN_RATE 48

// Widest beat taken from the buffer
`define SMP_OUT_MAX 32

// Stored coefficient width
`define SMP_COEF_W 16

`define SMP_FIFO_DEPTH 8

// Wishbone address and data widths
`define SMP_WB_AW 5
`define SMP_WB_DW 32

`endif

// ==== logic/sampler_cfg_pkg.sv ====
// Sampling mode type and per-mode widths, modulus and beat rate shared by the sampler
package sampler_cfg_pkg;

  // Mode 0 is 12-bit candidates, mode 1 is 16-bit candidates
  typedef enum logic {
    MODE_K12 = 1'b0,
    MODE_K16 = 1'b1
  } smp_mode_e;

  // Beat width taken from the buffer per read
  function automatic int unsigned mode_out_rate(smp_mode_e mode);
    return (mode == MODE_K16) ? 32 : 24;
  endfunction

  // Candidate width, two candidates per beat
  function automatic int unsigned mode_cand_w(smp_mode_e mode);
    return (mode == MODE_K16) ? 16 : 12;
  endfunction

  // Candidates at or above this value are rejected
  function automatic int unsigned mode_modulus(smp_mode_e mode);
    return (mode == MODE_K16) ? 65521 : 3329;
  endfunction

endpackage

// ==== logic/sampler_bus_pkg.sv ====
// Wishbone register map and slave FSM states for the sampler register block
`include "sampler_params.svh"

package sampler_bus_pkg;

  // Byte offsets of the host registers
  typedef enum logic [`SMP_WB_AW-1:0] {
    REG_CTRL    = 5'h00,
    REG_DATA_LO = 5'h04,
    REG_DATA_HI = 5'h08,
    REG_STATUS  = 5'h0C,
    REG_COEF    = 5'h10
  } smp_reg_e;

  // WB_PUSH waits for the buffer to take a block
  typedef enum logic [1:0] {
    WB_IDLE = 2'd0,
    WB_PUSH = 2'd1,
    WB_ACK  = 2'd2
  } wb_state_e;

endpackage

// ==== logic/piso_multi.sv ====
// Shift buffer that takes 48-bit blocks and hands out mode-sized beats under valid/hold
`include "sampler_params.svh"

module piso_multi (
  input  logic                       clk,
  input  logic                       rst_b,
  input  logic                       zeroize_i,
  input  sampler_cfg_pkg::smp_mode_e mode_i,
  input  logic                       valid_i,
  output logic                       hold_o,
  input  logic [`SMP_IN_RATE-1:0]    data_i,
  output logic                       valid_o,
  input  logic                       hold_i,
  output logic [`SMP_OUT_MAX-1:0]    data_o
);

  import sampler_cfg_pkg::*;

  localparam int PTR_W = $clog2(`SMP_BUF_W + 1);
  localparam int PAD_W = `SMP_BUF_W - `SMP_IN_RATE;

  logic [`SMP_BUF_W-1:0] buf_q;
  logic [`SMP_BUF_W-1:0] buf_d;
  logic [`SMP_BUF_W-1:0] buf_shift;
  logic [`SMP_BUF_W-1:0] wr_data;
  logic [PTR_W-1:0]      ptr_q;
  logic [PTR_W-1:0]      ptr_d;
  logic [PTR_W-1:0]      out_rate;
  logic [PTR_W-1:0]      wr_pos;
  logic [PTR_W-1:0]      room_lim;
  logic                  do_wr;
  logic                  do_rd;

  assign out_rate = PTR_W'(mode_out_rate(mode_i));

  // Highest fill that still leaves room for a whole block
  assign room_lim = PTR_W'(`SMP_BUF_W - `SMP_IN_RATE);

  assign valid_o = ptr_q >= out_rate;
  assign data_o  = buf_q[`SMP_OUT_MAX-1:0];

  assign do_rd = valid_o & ~hold_i;

  // A read in the same cycle frees one beat of space
  assign hold_o = do_rd ? (ptr_q > room_lim + out_rate) : (ptr_q > room_lim);
  assign do_wr  = valid_i & ~hold_o;

  // New block lands just above the bits that remain after the read
  assign wr_pos  = do_rd ? ptr_q - out_rate : ptr_q;
  assign wr_data = {{PAD_W{1'b0}}, data_i} << wr_pos;

  // Bits above the pointer are always zero, so an OR places the block
  always_comb begin
    buf_shift = do_rd ? (buf_q >> out_rate) : buf_q;
    buf_d     = do_wr ? (buf_shift | wr_data) : buf_shift;
  end

  always_comb begin
    ptr_d = ptr_q;
    if (do_rd) begin
      ptr_d = ptr_d - out_rate;
    end
    if (do_wr) begin
      ptr_d = ptr_d + PTR_W'(`SMP_IN_RATE);
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      buf_q <= '0;
      ptr_q <= '0;
    end else if (zeroize_i) begin
      buf_q <= '0;
      ptr_q <= '0;
    end else if (do_rd || do_wr) begin
      buf_q <= buf_d;
      ptr_q <= ptr_d;
    end
  end

endmodule

// ==== logic/reject_lane.sv ====
// One rejection lane: picks its half of a beat, masks it and flags it kept if below the modulus
`include "sampler_params.svh"

module reject_lane #(
  parameter int LANE_IDX = 0
) (
  input  logic                       clk,
  input  logic                       rst_b,
  input  logic                       zeroize_i,
  input  sampler_cfg_pkg::smp_mode_e mode_i,
  input  logic                       valid_i,
  input  logic [`SMP_OUT_MAX-1:0]    beat_i,
  input  logic                       hold_i,
  output logic                       hold_o,
  output logic                       valid_o,
  output logic                       keep_o,
  output logic [`SMP_COEF_W-1:0]     coef_o
);

  import sampler_cfg_pkg::*;

  logic [4:0]              cand_w;
  logic [4:0]              lane_ofs;
  logic [`SMP_OUT_MAX-1:0] beat_shift;
  logic [`SMP_COEF_W-1:0]  cand_mask;
  logic [`SMP_COEF_W-1:0]  cand;
  logic [`SMP_COEF_W-1:0]  modulus;
  logic                    load;

  assign cand_w  = 5'(mode_cand_w(mode_i));
  assign modulus = `SMP_COEF_W'(mode_modulus(mode_i));

  // Lane 1 starts one candidate width up the beat
  assign lane_ofs   = (LANE_IDX == 0) ? 5'd0 : cand_w;
  assign beat_shift = beat_i >> lane_ofs;
  assign cand_mask  = `SMP_COEF_W'((17'h1 << cand_w) - 17'h1);
  assign cand       = beat_shift[`SMP_COEF_W-1:0] & cand_mask;

  // Stall only while a result sits here unclaimed
  assign hold_o = valid_o & hold_i;
  assign load   = ~hold_o;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      valid_o <= 1'b0;
      keep_o  <= 1'b0;
    end else if (zeroize_i) begin
      valid_o <= 1'b0;
      keep_o  <= 1'b0;
    end else if (load) begin
      valid_o <= valid_i;
      keep_o  <= valid_i & (cand < modulus);
    end
  end

  always_ff @(posedge clk) begin
    if (load && valid_i) begin
      coef_o <= cand;
    end
  end

endmodule

// ==== logic/coef_merge.sv ====
// Packs kept coefficients from both lanes into a small in-order FIFO read by the host
`include "sampler_params.svh"

module coef_merge (
  input  logic                               clk,
  input  logic                               rst_b,
  input  logic                               zeroize_i,
  input  logic                               valid0_i,
  input  logic                               keep0_i,
  input  logic [`SMP_COEF_W-1:0]             coef0_i,
  input  logic                               valid1_i,
  input  logic                               keep1_i,
  input  logic [`SMP_COEF_W-1:0]             coef1_i,
  output logic                               hold_o,
  input  logic                               pop_i,
  output logic                               coef_valid_o,
  output logic [`SMP_COEF_W-1:0]             coef_o,
  output logic [$clog2(`SMP_FIFO_DEPTH):0]   count_o
);

  localparam int DEPTH = `SMP_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam int CW    = AW + 1;

  logic [`SMP_COEF_W-1:0] mem [DEPTH];
  logic [AW-1:0]          wr_ptr_q;
  logic [AW-1:0]          rd_ptr_q;
  logic [CW-1:0]          count_q;
  logic [AW-1:0]          slot1;
  logic [1:0]             n_wr;
  logic                   take;
  logic                   wr0;
  logic                   wr1;

  // A pair may need two slots
  assign hold_o = count_q > CW'(DEPTH - 2);

  assign take   = valid0_i & valid1_i & ~hold_o;
  assign wr0    = take & keep0_i;
  assign wr1    = take & keep1_i;
  assign n_wr   = {1'b0, wr0} + {1'b0, wr1};
  assign slot1  = wr_ptr_q + AW'(wr0);

  assign coef_valid_o = count_q != '0;
  assign coef_o       = mem[rd_ptr_q];
  assign count_o      = count_q;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (zeroize_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + AW'(n_wr);
      rd_ptr_q <= rd_ptr_q + AW'(pop_i);
      count_q  <= count_q + CW'(n_wr) - CW'(pop_i);
    end
  end

  // Lane 0 goes first when both are kept
  always_ff @(posedge clk) begin
    if (zeroize_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (wr0) begin
        mem[wr_ptr_q] <= coef0_i;
      end
      if (wr1) begin
        mem[slot1] <= coef1_i;
      end
    end
  end

endmodule

// ==== logic/wb_sampler_regs.sv ====
// Wishbone classic slave with control, block push, status and coefficient pop registers
`include "sampler_params.svh"

module wb_sampler_regs (
  input  logic                               clk,
  input  logic                               rst_b,
  input  logic                               wb_cyc_i,
  input  logic                               wb_stb_i,
  input  logic                               wb_we_i,
  input  logic [`SMP_WB_AW-1:0]              wb_adr_i,
  input  logic [`SMP_WB_DW-1:0]              wb_dat_i,
  input  logic [`SMP_WB_DW/8-1:0]            wb_sel_i,
  output logic                               wb_ack_o,
  output logic [`SMP_WB_DW-1:0]              wb_dat_o,
  output sampler_cfg_pkg::smp_mode_e         mode_o,
  output logic                               zeroize_o,
  output logic                               blk_valid_o,
  output logic [`SMP_IN_RATE-1:0]            blk_data_o,
  input  logic                               blk_hold_i,
  input  logic                               coef_valid_i,
  input  logic [`SMP_COEF_W-1:0]             coef_i,
  input  logic [$clog2(`SMP_FIFO_DEPTH):0]   count_i,
  output logic                               coef_pop_o
);

  import sampler_cfg_pkg::*;
  import sampler_bus_pkg::*;

  localparam int HI_W = `SMP_IN_RATE - `SMP_WB_DW;

  wb_state_e             state_q;
  smp_reg_e              reg_sel;
  logic [`SMP_WB_DW-1:0] data_lo_q;
  logic [`SMP_WB_DW-1:0] rd_data;
  logic                  req;
  logic                  hi_write;

  // Ignore the strobe during the ack cycle, the master drops it next
  assign req      = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign reg_sel  = smp_reg_e'(wb_adr_i);
  assign hi_write = wb_we_i & (reg_sel == REG_DATA_HI);

  always_comb begin
    rd_data = '0;
    case (reg_sel)
      REG_CTRL:    rd_data[0] = mode_o;
      REG_DATA_LO: rd_data = data_lo_q;
      REG_STATUS:  rd_data[$clog2(`SMP_FIFO_DEPTH):0] = count_i;
      REG_COEF:    rd_data = {coef_valid_i, {(`SMP_WB_DW-`SMP_COEF_W-1){1'b0}}, coef_i};
      default:     rd_data = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q     <= WB_IDLE;
      wb_ack_o    <= 1'b0;
      blk_valid_o <= 1'b0;
      zeroize_o   <= 1'b0;
      coef_pop_o  <= 1'b0;
      mode_o      <= MODE_K12;
    end else begin
      wb_ack_o   <= 1'b0;
      zeroize_o  <= 1'b0;
      coef_pop_o <= 1'b0;
      case (state_q)
        WB_IDLE: begin
          if (req && hi_write) begin
            blk_valid_o <= 1'b1;
            state_q     <= WB_PUSH;
          end else if (req) begin
            state_q <= WB_ACK;
          end
        end
        // Block is taken in a cycle with hold low
        WB_PUSH: begin
          if (!blk_hold_i) begin
            blk_valid_o <= 1'b0;
            wb_ack_o    <= 1'b1;
            state_q     <= WB_IDLE;
          end
        end
        WB_ACK: begin
          wb_ack_o <= 1'b1;
          state_q  <= WB_IDLE;
          if (wb_we_i && reg_sel == REG_CTRL && wb_sel_i[0]) begin
            mode_o    <= smp_mode_e'(wb_dat_i[0]);
            zeroize_o <= wb_dat_i[1];
          end
          if (!wb_we_i && reg_sel == REG_COEF) begin
            coef_pop_o <= coef_valid_i;
          end
        end
        default: state_q <= WB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == WB_IDLE && req && hi_write) begin
      blk_data_o <= {wb_dat_i[HI_W-1:0], data_lo_q};
    end
    if (state_q == WB_ACK && wb_we_i && reg_sel == REG_DATA_LO) begin
      for (int b = 0; b < `SMP_WB_DW / 8; b++) begin
        if (wb_sel_i[b]) begin
          data_lo_q[b*8 +: 8] <= wb_dat_i[b*8 +: 8];
        end
      end
    end
    // Read data is captured with the head of the FIFO before the pop
    if (state_q == WB_ACK && !wb_we_i) begin
      wb_dat_o <= rd_data;
    end
  end

endmodule

// ==== logic/coef_sampler_top.sv ====
// Top of the coefficient sampler: bus slave, shift buffer, two rejection lanes and merge FIFO
`include "sampler_params.svh"

module coef_sampler_top (
  input  logic                    clk,
  input  logic                    rst_b,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  logic [`SMP_WB_AW-1:0]   wb_adr_i,
  input  logic [`SMP_WB_DW-1:0]   wb_dat_i,
  input  logic [`SMP_WB_DW/8-1:0] wb_sel_i,
  output logic                    wb_ack_o,
  output logic [`SMP_WB_DW-1:0]   wb_dat_o
);

  import sampler_cfg_pkg::*;

  smp_mode_e                         mode;
  logic                              zeroize;
  logic                              blk_valid;
  logic                              blk_hold;
  logic [`SMP_IN_RATE-1:0]           blk_data;
  logic                              beat_valid;
  logic                              beat_hold;
  logic [`SMP_OUT_MAX-1:0]           beat_data;
  logic                              lane_hold;
  logic                              lane0_valid;
  logic                              lane0_keep;
  logic [`SMP_COEF_W-1:0]            lane0_coef;
  logic                              lane1_valid;
  logic                              lane1_keep;
  logic [`SMP_COEF_W-1:0]            lane1_coef;
  logic                              coef_pop;
  logic                              coef_valid;
  logic [`SMP_COEF_W-1:0]            coef;
  logic [$clog2(`SMP_FIFO_DEPTH):0]  count;

  wb_sampler_regs regs_i (
    .clk          (clk),
    .rst_b        (rst_b),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_sel_i     (wb_sel_i),
    .wb_ack_o     (wb_ack_o),
    .wb_dat_o     (wb_dat_o),
    .mode_o       (mode),
    .zeroize_o    (zeroize),
    .blk_valid_o  (blk_valid),
    .blk_data_o   (blk_data),
    .blk_hold_i   (blk_hold),
    .coef_valid_i (coef_valid),
    .coef_i       (coef),
    .count_i      (count),
    .coef_pop_o   (coef_pop)
  );

  piso_multi piso_i (
    .clk       (clk),
    .rst_b     (rst_b),
    .zeroize_i (zeroize),
    .mode_i    (mode),
    .valid_i   (blk_valid),
    .hold_o    (blk_hold),
    .data_i    (blk_data),
    .valid_o   (beat_valid),
    .hold_i    (beat_hold),
    .data_o    (beat_data)
  );

  // Lanes move in lockstep, lane 0 stalls the buffer for both
  reject_lane #(.LANE_IDX(0)) lane0_i (
    .clk       (clk),
    .rst_b     (rst_b),
    .zeroize_i (zeroize),
    .mode_i    (mode),
    .valid_i   (beat_valid),
    .beat_i    (beat_data),
    .hold_i    (lane_hold),
    .hold_o    (beat_hold),
    .valid_o   (lane0_valid),
    .keep_o    (lane0_keep),
    .coef_o    (lane0_coef)
  );

  reject_lane #(.LANE_IDX(1)) lane1_i (
    .clk       (clk),
    .rst_b     (rst_b),
    .zeroize_i (zeroize),
    .mode_i    (mode),
    .valid_i   (beat_valid),
    .beat_i    (beat_data),
    .hold_i    (lane_hold),
    .hold_o    (),
    .valid_o   (lane1_valid),
    .keep_o    (lane1_keep),
    .coef_o    (lane1_coef)
  );

  coef_merge merge_i (
    .clk          (clk),
    .rst_b        (rst_b),
    .zeroize_i    (zeroize),
    .valid0_i     (lane0_valid),
    .keep0_i      (lane0_keep),
    .coef0_i      (lane0_coef),
    .valid1_i     (lane1_valid),
    .keep1_i      (lane1_keep),
    .coef1_i      (lane1_coef),
    .hold_o       (lane_hold),
    .pop_i        (coef_pop),
    .coef_valid_o (coef_valid),
    .coef_o       (coef),
    .count_o      (count)
  );

endmodule

// ==== bench/tb_coef_sampler.sv ====
// Testbench for the coefficient sampler, built and run by run_sim.sh under Verilator
`include "sampler_params.svh"

module tb_coef_sampler;

  timeunit 1ns;
  timeprecision 1ps;

  import sampler_cfg_pkg::*;
  import sampler_bus_pkg::*;

  typedef logic [`SMP_IN_RATE-1:0] blk_q_t[$];
  typedef logic [`SMP_COEF_W-1:0]  coef_q_t[$];

  localparam int ACK_TIMEOUT = 200;
  localparam int POLL_LIMIT  = 100;

  logic                    clk = 1'b0;
  logic                    rst_b;
  logic                    wb_cyc;
  logic                    wb_stb;
  logic                    wb_we;
  logic [`SMP_WB_AW-1:0]   wb_adr;
  logic [`SMP_WB_DW-1:0]   wb_dat_w;
  logic [`SMP_WB_DW/8-1:0] wb_sel;
  logic                    wb_ack;
  logic [`SMP_WB_DW-1:0]   wb_dat_r;

  logic [31:0] lcg_state;
  smp_mode_e   cur_mode;
  blk_q_t      phase_blocks;
  coef_q_t     exp_q;
  int          exp_idx;

  coef_sampler_top dut_i (
    .clk      (clk),
    .rst_b    (rst_b),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_sel_i (wb_sel),
    .wb_ack_o (wb_ack),
    .wb_dat_o (wb_dat_r)
  );

  always #5 clk = ~clk;

  // LCG with the usual C library constants
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Block built from the upper halves of three LCG words
  function automatic logic [47:0] random_block();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    r0 = next_rand();
    r1 = next_rand();
    r2 = next_rand();
    return {r2[31:16], r1[31:16], r0[31:16]};
  endfunction

  // 12-bit candidate below 3329 when keep is set, else in 3329..4095
  function automatic logic [11:0] k12_cand(input bit keep);
    logic [31:0] r;
    r = next_rand();
    if (keep) begin
      return 12'(r[31:16] % 3329);
    end else begin
      return 12'(3329 + r[31:16] % 767);
    end
  endfunction

  // Blocks joined LSB first and cut into whole beats of two candidates each
  function automatic coef_q_t ref_sample(input blk_q_t blocks, input smp_mode_e mode);
    coef_q_t      res;
    logic [127:0] acc;
    logic [15:0]  cand [2];
    logic [15:0]  modulus;
    int           rate;
    int           cw;
    int           fill;
    int           b;
    rate    = (mode == MODE_K16) ? 32 : 24;
    cw      = (mode == MODE_K16) ? 16 : 12;
    modulus = (mode == MODE_K16) ? 16'd65521 : 16'd3329;
    acc     = '0;
    fill    = 0;
    foreach (blocks[i]) begin
      acc  = acc | ({80'b0, blocks[i]} << fill);
      fill = fill + 48;
      while (fill >= rate) begin
        cand[0] = '0;
        cand[1] = '0;
        for (b = 0; b < cw; b++) begin
          cand[0][b] = acc[b];
          cand[1][b] = acc[cw + b];
        end
        for (b = 0; b < 2; b++) begin
          if (cand[b] < modulus) begin
            res.push_back(cand[b]);
          end
        end
        acc  = acc >> rate;
        fill = fill - rate;
      end
    end
    return res;
  endfunction

  task automatic stop_with_failure(input string what);
    $display("*** TEST FAILED ***");
    $fatal(1, "%s", what);
  endtask

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0d ns: %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
      stop_with_failure("a value check failed");
    end
  endtask

  task automatic wb_write(input smp_reg_e addr, input logic [31:0] data);
    int cycles;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= addr;
    wb_dat_w <= data;
    wb_sel   <= 4'hF;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > ACK_TIMEOUT) begin
        stop_with_failure("bus ack never arrived on a write");
      end
    end while (!wb_ack);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_read(input smp_reg_e addr, output logic [31:0] data);
    int cycles;
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= addr;
    wb_sel <= 4'hF;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > ACK_TIMEOUT) begin
        stop_with_failure("bus ack never arrived on a read");
      end
    end while (!wb_ack);
    data = wb_dat_r;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  // Zeroize starts a new stream, so the expected sequence restarts
  task automatic set_ctrl(input smp_mode_e mode, input bit zeroize);
    wb_write(REG_CTRL, {30'h0, zeroize, mode});
    cur_mode = mode;
    if (zeroize) begin
      phase_blocks.delete();
      exp_q.delete();
      exp_idx = 0;
    end
  endtask

  task automatic push_block(input logic [47:0] blk);
    wb_write(REG_DATA_LO, blk[31:0]);
    wb_write(REG_DATA_HI, {16'h0, blk[47:32]});
    phase_blocks.push_back(blk);
    exp_q = ref_sample(phase_blocks, cur_mode);
  endtask

  task automatic read_count(output int count);
    logic [31:0] rd;
    wb_read(REG_STATUS, rd);
    count = int'(rd[3:0]);
    if (rd[31:4] != '0 || count > `SMP_FIFO_DEPTH) begin
      stop_with_failure("STATUS reports a count above the FIFO depth");
    end
  endtask

  // Reads COEF until every expected value has arrived and a read comes back empty
  task automatic drain_fifo();
    logic [31:0] rd;
    int          polls;
    bit          done;
    polls = 0;
    done  = 1'b0;
    while (!done) begin
      polls++;
      if (polls > POLL_LIMIT) begin
        stop_with_failure("FIFO did not deliver all expected coefficients");
      end else begin
        wb_read(REG_COEF, rd);
        if (rd[31] && exp_idx >= exp_q.size()) begin
          stop_with_failure("FIFO returned a coefficient beyond the expected sequence");
        end else if (rd[31]) begin
          check_equal(32'(rd[15:0]), 32'(exp_q[exp_idx]), $sformatf("coefficient %0d", exp_idx));
          exp_idx++;
        end else if (exp_idx == exp_q.size()) begin
          done = 1'b1;
        end
      end
    end
  endtask

  initial begin
    logic [31:0] rd;
    logic [47:0] blk;
    int          count;
    int          polls;
    int          n;
    rst_b    <= 1'b0;
    wb_cyc   <= 1'b0;
    wb_stb   <= 1'b0;
    wb_we    <= 1'b0;
    wb_adr   <= '0;
    wb_dat_w <= '0;
    wb_sel   <= '0;
    lcg_state = 32'd93;
    cur_mode  = MODE_K12;
    exp_idx   = 0;
    repeat (4) @(posedge clk);
    rst_b <= 1'b1;

    wb_read(REG_STATUS, rd);
    check_equal(rd, 32'h0, "STATUS after reset");
    wb_read(REG_COEF, rd);
    check_equal(32'(rd[31]), 32'h0, "COEF valid bit after reset");

    // Random mode 0 blocks drained one by one
    for (n = 0; n < 6; n++) begin
      push_block(random_block());
      drain_fifo();
    end

    // Mode 1 blocks with forced values at the modulus boundary in beats that may span two blocks
    set_ctrl(MODE_K16, 1'b1);
    for (n = 0; n < 6; n++) begin
      blk = random_block();
      case (n)
        0: blk[47:32] = 16'hFFF0;
        1: blk[15:0]  = 16'hFFF1;
        2: blk[31:16] = 16'hFFF1 + 16'(next_rand() % 15);
        3: blk[47:32] = 16'hFFFF;
        4: blk[15:0]  = 16'hFFF8;
        default: ;
      endcase
      push_block(blk);
      drain_fifo();
    end

    // Nine rejected blocks then three kept ones fill the FIFO and stall the lanes
    set_ctrl(MODE_K12, 1'b1);
    for (n = 0; n < 12; n++) begin
      blk = {k12_cand(n >= 9), k12_cand(n >= 9), k12_cand(n >= 9), k12_cand(n >= 9)};
      push_block(blk);
      read_count(count);
    end
    polls = 0;
    count = 0;
    while (count != `SMP_FIFO_DEPTH) begin
      polls++;
      if (polls > POLL_LIMIT) begin
        stop_with_failure("FIFO never filled up under back-pressure");
      end else begin
        read_count(count);
      end
    end
    drain_fifo();

    // Zeroize in the middle of a stream
    for (n = 0; n < 3; n++) begin
      push_block(random_block());
    end
    set_ctrl(MODE_K12, 1'b1);
    wb_read(REG_STATUS, rd);
    check_equal(rd, 32'h0, "STATUS after zeroize");
    wb_read(REG_COEF, rd);
    check_equal(rd, 32'h0, "COEF after zeroize");
    push_block({12'd4095, 12'd0, 12'd3329, 12'd3328});
    drain_fifo();
    push_block(random_block());
    drain_fifo();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+logic
logic/sampler_cfg_pkg.sv
logic/sampler_bus_pkg.sv
logic/piso_multi.sv
logic/reject_lane.sv
logic/coef_merge.sv
logic/wb_sampler_regs.sv
logic/coef_sampler_top.sv
bench/tb_coef_sampler.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing -f filelist.f --top-module tb_coef_sampler -o tb_coef_sampler \
  && ./obj_dir/tb_coef_sampler \
  || exit 1
